/* rtl/nnPkg.sv */
package nnPkg;

	localparam int FeatureCount = 15;
	localparam int HiddenCount = 6;
	localparam int ClassCount = 3;
	localparam int FracBits = 8;
	localparam int MaxInputs = 15; // Widest weight row a node reads

	typedef logic signed [15:0] fixT; // Q8.8

	typedef fixT [FeatureCount-1:0] featureVecT;
	typedef fixT [HiddenCount-1:0] hiddenVecT;
	typedef fixT [ClassCount-1:0] scoreVecT;

	typedef struct packed
	{
		logic [1:0] classIdx;
		fixT score;
	} resultT;

	// Hidden layer, one row per node, element 0 weighs feature 0
	localparam fixT HiddenWeights [HiddenCount][FeatureCount] = '{
		'{-16'sd450, 16'sd244, 16'sd295, -16'sd37, -16'sd212, -16'sd353, 16'sd249,
			-16'sd177, -16'sd16, -16'sd502, 16'sd183, 16'sd311, -16'sd336, -16'sd112,
			-16'sd475},
		'{16'sd128, -16'sd64, 16'sd300, 16'sd210, -16'sd90, 16'sd45, -16'sd260,
			16'sd180, 16'sd75, -16'sd30, 16'sd400, -16'sd150, 16'sd95, 16'sd60,
			-16'sd220},
		'{-16'sd200, 16'sd330, -16'sd45, 16'sd120, 16'sd260, -16'sd310, 16'sd15,
			16'sd90, -16'sd175, 16'sd240, -16'sd60, 16'sd135, -16'sd285, 16'sd205,
			16'sd70},
		// Unit weights, drives the node into saturation on large inputs
		'{16'sd256, 16'sd256, 16'sd256, 16'sd256, 16'sd256, 16'sd256, 16'sd256,
			16'sd256, 16'sd256, 16'sd256, 16'sd256, 16'sd256, 16'sd256, 16'sd256,
			16'sd256},
		'{16'sd35, -16'sd140, 16'sd190, -16'sd80, 16'sd310, 16'sd25, -16'sd205,
			16'sd160, -16'sd95, 16'sd275, -16'sd130, 16'sd50, 16'sd215, -16'sd265,
			16'sd110},
		'{-16'sd256, -16'sd256, -16'sd256, -16'sd256, -16'sd256, -16'sd256, -16'sd256,
			-16'sd256, -16'sd256, -16'sd256, -16'sd256, -16'sd256, -16'sd256, -16'sd256,
			-16'sd256}
	};

	// Negative biases so a zero vector leaves every hidden node at zero
	localparam fixT HiddenBias [HiddenCount] = '{
		-16'sd64, -16'sd32, 16'sd0, -16'sd128, -16'sd16, -16'sd8
	};

	localparam fixT OutWeights [ClassCount][HiddenCount] = '{
		'{16'sd300, -16'sd120, 16'sd210, 16'sd90, -16'sd250, 16'sd180},
		'{-16'sd140, 16'sd260, 16'sd75, -16'sd200, 16'sd330, -16'sd60},
		'{16'sd220, 16'sd150, -16'sd310, 16'sd170, 16'sd40, -16'sd190}
	};

	// Equal biases, so equal hidden activity gives a tie
	localparam fixT OutBias [ClassCount] = '{
		16'sd32, 16'sd32, 16'sd32
	};

endpackage

/* rtl/featureReceiver.sv */
`timescale 1ns/1ps

module featureReceiver
(
	input logic clk,
	input logic reset,
	input logic featReq,
	input nnPkg::fixT featData,
	output logic featAck,
	input logic accept,
	output logic vecValid,
	output nnPkg::featureVecT vec
);

	logic [$clog2(nnPkg::FeatureCount)-1:0] slotCnt;
	logic capture;
	logic lastSlot;

	// First feature of a vector waits for accept, later ones do not
	assign capture = featReq && !featAck && (accept || slotCnt != '0);
	assign lastSlot = (int'(slotCnt) == nnPkg::FeatureCount - 1);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			featAck <= 1'b0;
			slotCnt <= '0;
			vecValid <= 1'b0;
		end
		else
		begin
			vecValid <= 1'b0;
			if (capture)
			begin
				featAck <= 1'b1;
				if (lastSlot)
				begin
					slotCnt <= '0;
					vecValid <= 1'b1; // Whole vector in place
				end
				else
				begin
					slotCnt <= slotCnt + 1'b1;
				end
			end
			else if (!featReq)
			begin
				featAck <= 1'b0; // Host dropped req, finish the transfer
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
			vec[slotCnt] <= featData;
	end

endmodule

/* rtl/neuronNode.sv */
`timescale 1ns/1ps

module neuronNode
#(
	parameter int Inputs = 15,
	parameter int Layer = 0,
	parameter int Node = 0,
	parameter bit Relu = 1'b1
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnPkg::fixT [nnPkg::MaxInputs-1:0] x,
	output logic outValid,
	output nnPkg::fixT y
);

	nnPkg::fixT [nnPkg::MaxInputs-1:0] w;
	nnPkg::fixT bias;
	nnPkg::fixT [nnPkg::MaxInputs-1:0] xReg;
	logic signed [39:0] sum;
	logic signed [39:0] acc;
	logic signed [39:0] shifted;
	nnPkg::fixT yNext;
	logic s1Valid;
	logic s2Valid;

	// Constant weight row for this node, unused slots are zero
	for (genvar i = 0; i < nnPkg::MaxInputs; i++)
	begin : genWeight
		if (i >= Inputs)
			assign w[i] = '0;
		else if (Layer == 0)
			assign w[i] = nnPkg::HiddenWeights[Node][i];
		else
			assign w[i] = nnPkg::OutWeights[Node][i];
	end

	if (Layer == 0)
	begin : genHiddenBias
		assign bias = nnPkg::HiddenBias[Node];
	end
	else
	begin : genOutBias
		assign bias = nnPkg::OutBias[Node];
	end

	always_comb
	begin
		logic signed [31:0] prod;
		sum = bias <<< nnPkg::FracBits; // Bias lined up with the Q16.16 products
		for (int i = 0; i < nnPkg::MaxInputs; i++)
		begin
			prod = xReg[i] * w[i];
			sum = sum + prod;
		end
	end

	assign shifted = acc >>> nnPkg::FracBits;

	always_comb
	begin
		if (shifted > 40'sd32767)
			yNext = 16'sh7fff;
		else if (shifted < -40'sd32768)
			yNext = 16'sh8000;
		else
			yNext = shifted[15:0];
		if (Relu && yNext < 0)
			yNext = '0;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
			outValid <= 1'b0;
		end
		else
		begin
			s1Valid <= inValid;
			s2Valid <= s1Valid;
			outValid <= s2Valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (inValid)
			xReg <= x;
		if (s1Valid)
			acc <= sum;
		if (s2Valid)
			y <= yNext;
	end

endmodule

/* rtl/denseLayer.sv */
`timescale 1ns/1ps

module denseLayer
#(
	parameter int Layer = 0,
	parameter int Inputs = 15,
	parameter int Nodes = 6,
	parameter bit Relu = 1'b1
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnPkg::fixT [Inputs-1:0] x,
	output logic outValid,
	output nnPkg::fixT [Nodes-1:0] y
);

	nnPkg::fixT [nnPkg::MaxInputs-1:0] xWide;
	logic [Nodes-1:0] nodeValid;

	// Pad short input vectors up to the full node width
	for (genvar i = 0; i < nnPkg::MaxInputs; i++)
	begin : genPad
		if (i < Inputs)
			assign xWide[i] = x[i];
		else
			assign xWide[i] = '0;
	end

	for (genvar n = 0; n < Nodes; n++)
	begin : genNode
		neuronNode #(.Inputs(Inputs), .Layer(Layer), .Node(n), .Relu(Relu)) node
		(
			.clk(clk),
			.reset(reset),
			.inValid(inValid),
			.x(xWide),
			.outValid(nodeValid[n]),
			.y(y[n])
		);
	end

	assign outValid = nodeValid[0]; // All nodes run in lockstep

endmodule

/* rtl/classSelector.sv */
`timescale 1ns/1ps

module classSelector
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnPkg::scoreVecT scores,
	output logic outValid,
	output nnPkg::resultT sel
);

	nnPkg::fixT best;
	logic [1:0] bestIdx;

	always_comb
	begin
		best = scores[0];
		bestIdx = 2'd0;
		for (int i = 1; i < nnPkg::ClassCount; i++)
		begin
			// Strict compare keeps the lowest index on a tie
			if (scores[i] > best)
			begin
				best = scores[i];
				bestIdx = 2'(i);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			outValid <= 1'b0;
		else
			outValid <= inValid;
	end

	always_ff @(posedge clk)
	begin
		if (inValid)
		begin
			sel.classIdx <= bestIdx;
			sel.score <= best;
		end
	end

endmodule

/* rtl/resultSender.sv */
`timescale 1ns/1ps

module resultSender
(
	input logic clk,
	input logic reset,
	input logic vecValid,
	input logic selValid,
	input nnPkg::resultT sel,
	output logic accept,
	output logic resultReq,
	output nnPkg::resultT resultData,
	input logic resultAck
);

	typedef enum logic [1:0]
	{
		Idle,
		Busy,
		SendReq,
		WaitDrop
	} stateT;

	stateT state;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= Idle;
		end
		else
		begin
			case (state)
				Idle:
					if (vecValid)
						state <= Busy; // Vector in the pipeline
				Busy:
					if (selValid)
						state <= SendReq;
				SendReq:
					if (resultAck)
						state <= WaitDrop;
				WaitDrop:
					if (!resultAck)
						state <= Idle; // Handoff done
				default:
					state <= Idle;
			endcase
		end
	end

	// Result held through the whole handshake
	always_ff @(posedge clk)
	begin
		if (state == Busy && selValid)
			resultData <= sel;
	end

	assign accept = (state == Idle);
	assign resultReq = (state == SendReq);

endmodule

/* rtl/inferenceTop.sv */
`timescale 1ns/1ps

module inferenceTop
(
	input logic clk,
	input logic reset,
	input logic featReq,
	input nnPkg::fixT featData,
	output logic featAck,
	output logic resultReq,
	output nnPkg::resultT resultData,
	input logic resultAck
);

	logic accept;
	logic vecValid;
	nnPkg::featureVecT vec;
	logic hidValid;
	nnPkg::hiddenVecT hid;
	logic scoreValid;
	nnPkg::scoreVecT scores;
	logic selValid;
	nnPkg::resultT sel;

	featureReceiver receiver
	(
		.clk(clk),
		.reset(reset),
		.featReq(featReq),
		.featData(featData),
		.featAck(featAck),
		.accept(accept),
		.vecValid(vecValid),
		.vec(vec)
	);

	denseLayer #(.Layer(0), .Inputs(nnPkg::FeatureCount), .Nodes(nnPkg::HiddenCount),
		.Relu(1'b1)) hiddenLayer
	(
		.clk(clk),
		.reset(reset),
		.inValid(vecValid),
		.x(vec),
		.outValid(hidValid),
		.y(hid)
	);

	// Raw scores, no ReLU on the output layer
	denseLayer #(.Layer(1), .Inputs(nnPkg::HiddenCount), .Nodes(nnPkg::ClassCount),
		.Relu(1'b0)) outputLayer
	(
		.clk(clk),
		.reset(reset),
		.inValid(hidValid),
		.x(hid),
		.outValid(scoreValid),
		.y(scores)
	);

	classSelector selector
	(
		.clk(clk),
		.reset(reset),
		.inValid(scoreValid),
		.scores(scores),
		.outValid(selValid),
		.sel(sel)
	);

	resultSender sender
	(
		.clk(clk),
		.reset(reset),
		.vecValid(vecValid),
		.selValid(selValid),
		.sel(sel),
		.accept(accept),
		.resultReq(resultReq),
		.resultData(resultData),
		.resultAck(resultAck)
	);

endmodule

/* dv/inferenceChecker.sv */
`timescale 1ns/1ps

module inferenceChecker
(
	input logic clk,
	input logic reset,
	input logic featReq,
	input logic featAck,
	input nnPkg::fixT featData,
	input logic resultReq,
	input logic resultAck,
	input nnPkg::resultT resultData,
	input logic tableExpValid,
	input nnPkg::resultT tableExp,
	output int passCount,
	output int errorCount,
	output int resultCount
);

	nnPkg::fixT feats [nnPkg::FeatureCount];
	nnPkg::resultT expQ [$];
	nnPkg::resultT heldData;
	nnPkg::resultT expected;
	int slot;
	int vecCount;
	logic ackPrev;
	logic featReqPrev;
	logic reqPrev;
	logic resetPrev;

	// Drop the fraction bits, then clamp to the Q8.8 range
	function automatic nnPkg::fixT saturate(input logic signed [39:0] s);
		logic signed [39:0] t;
		t = s >>> nnPkg::FracBits;
		if (t > 40'sd32767)
			return 16'sh7fff;
		if (t < -40'sd32768)
			return 16'sh8000;
		return t[15:0];
	endfunction

	function automatic nnPkg::resultT reference(input nnPkg::fixT f [nnPkg::FeatureCount]);
		nnPkg::fixT hid [nnPkg::HiddenCount];
		nnPkg::fixT score;
		logic signed [39:0] acc;
		logic signed [31:0] prod;
		nnPkg::resultT best;
		best = '0;
		for (int n = 0; n < nnPkg::HiddenCount; n++)
		begin
			acc = nnPkg::HiddenBias[n];
			acc = acc <<< nnPkg::FracBits;
			for (int i = 0; i < nnPkg::FeatureCount; i++)
			begin
				prod = f[i] * nnPkg::HiddenWeights[n][i];
				acc = acc + prod;
			end
			hid[n] = saturate(acc);
			if (hid[n] < 0)
				hid[n] = '0; // ReLU
		end
		for (int c = 0; c < nnPkg::ClassCount; c++)
		begin
			acc = nnPkg::OutBias[c];
			acc = acc <<< nnPkg::FracBits;
			for (int i = 0; i < nnPkg::HiddenCount; i++)
			begin
				prod = hid[i] * nnPkg::OutWeights[c][i];
				acc = acc + prod;
			end
			score = saturate(acc);
			if (c == 0 || score > best.score) // First maximum wins a tie
			begin
				best.classIdx = 2'(c);
				best.score = score;
			end
		end
		return best;
	endfunction

	always @(posedge clk)
	begin
		if (reset)
		begin
			passCount = 0;
			errorCount = 0;
			resultCount = 0;
			vecCount = 0;
			slot = 0;
			ackPrev = 1'b0;
			featReqPrev = 1'b0;
			reqPrev = 1'b0;
			expQ.delete();
		end
		else
		begin
			if (resetPrev && (featAck !== 1'b0 || resultReq !== 1'b0))
			begin
				$display("Handshake outputs not low after reset");
				errorCount++;
			end
			// Ack seen one edge after the capture, req may already be gone
			if (featAck && !ackPrev && featReqPrev)
			begin
				if (resultReq && !resultAck)
				begin
					$display("Feature accepted while a result was still pending");
					errorCount++;
				end
				feats[slot] = featData;
				slot++;
				if (slot == nnPkg::FeatureCount)
				begin
					slot = 0;
					expected = reference(feats);
					if (tableExpValid && expected !== tableExp)
					begin
						$display("Reference model and stimulus table disagree on vector %0d",
							vecCount);
						errorCount++;
					end
					expQ.push_back(expected);
					vecCount++;
				end
			end
			if (resultReq && !reqPrev)
			begin
				heldData = resultData;
				if (expQ.size() == 0)
				begin
					$display("Test %0d: result arrived with no vector sent", resultCount);
					errorCount++;
				end
				else
				begin
					expected = expQ.pop_front();
					if (resultData !== expected)
					begin
						$display("Error resultData test %0d: expected %h, actual %h",
							resultCount, expected, resultData);
						errorCount++;
					end
					else
					begin
						$display("Test %0d: passed, class %0d score %h", resultCount,
							resultData.classIdx, resultData.score);
						passCount++;
					end
				end
				resultCount++;
			end
			else if (reqPrev && resultReq && resultData !== heldData)
			begin
				$display("Error resultData changed during handshake: held %h, now %h",
					heldData, resultData);
				errorCount++;
			end
			ackPrev = featAck;
			featReqPrev = featReq;
			reqPrev = resultReq;
		end
		resetPrev = reset;
	end

endmodule

/* dv/inferenceTb.sv */
`timescale 1ns/1ps

module inferenceTb;

	localparam int TestCount = 16;
	localparam int CycleLimit = TestCount * (nnPkg::FeatureCount * 10 + 60);

	typedef struct packed
	{
		nnPkg::featureVecT feats;
		logic [3:0] ackDelay; // Cycles the host waits before resultAck
		logic hasExp;
		nnPkg::resultT exp;
	} testT;

	logic clk;
	logic reset;
	logic featReq;
	nnPkg::fixT featData;
	logic featAck;
	logic resultReq;
	nnPkg::resultT resultData;
	logic resultAck;
	logic tableExpValid;
	nnPkg::resultT tableExp;
	logic ackDone;
	int passCount;
	int errorCount;
	int resultCount;
	int cycles;
	logic [31:0] lcg;
	testT tests [TestCount];

	inferenceTop DUT
	(
		.clk(clk),
		.reset(reset),
		.featReq(featReq),
		.featData(featData),
		.featAck(featAck),
		.resultReq(resultReq),
		.resultData(resultData),
		.resultAck(resultAck)
	);

	inferenceChecker resultCheck
	(
		.clk(clk),
		.reset(reset),
		.featReq(featReq),
		.featAck(featAck),
		.featData(featData),
		.resultReq(resultReq),
		.resultAck(resultAck),
		.resultData(resultData),
		.tableExpValid(tableExpValid),
		.tableExp(tableExp),
		.passCount(passCount),
		.errorCount(errorCount),
		.resultCount(resultCount)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] nextRand(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic sendFeature(input nnPkg::fixT value);
		featData = value;
		featReq = 1'b1;
		while (!featAck)
			nextCycle();
		featReq = 1'b0;
		while (featAck)
			nextCycle();
	endtask

	task automatic buildTable();
		tests[0] = '0; // All zero, every hidden node stays at zero
		tests[0].hasExp = 1'b1;
		tests[0].exp = 18'h00020;
		tests[1] = '0;
		tests[1].feats = {nnPkg::FeatureCount{16'h7fff}};
		tests[1].ackDelay = 4'd3;
		tests[1].hasExp = 1'b1;
		tests[1].exp = 18'h17fff; // Class 1 clamps at the positive limit
		tests[2] = '0;
		tests[2].feats = {nnPkg::FeatureCount{16'h8000}};
		tests[2].hasExp = 1'b1;
		tests[2].exp = 18'h07fff;
		tests[3] = '0;
		tests[3].feats[0] = 16'h0100;
		tests[3].ackDelay = 4'd6;
		tests[3].hasExp = 1'b1;
		tests[3].exp = 18'h200b0;
		tests[4] = '0; // Classes 0 and 1 tie at 0x0020
		tests[4].feats = {nnPkg::FeatureCount{16'h0001}};
		tests[4].hasExp = 1'b1;
		tests[4].exp = 18'h00020;
		tests[5] = '0;
		tests[5].feats = {16'h8000, {7{16'h7fff, 16'h8000}}};
		tests[5].ackDelay = 4'd2;
		tests[6] = '0;
		tests[6].feats[14] = 16'h7fff;
		tests[7] = '0;
		tests[7].feats = {nnPkg::FeatureCount{16'h4000}};
		tests[7].ackDelay = 4'd4;
		lcg = 32'ha2d4994f;
		for (int k = 8; k < TestCount; k++)
		begin
			tests[k] = '0;
			for (int i = 0; i < nnPkg::FeatureCount; i++)
			begin
				lcg = nextRand(lcg);
				if (k % 2 == 0)
					tests[k].feats[i] = lcg[31:16];
				else
					tests[k].feats[i] = $signed(lcg[31:20]); // Within +-8.0
			end
			lcg = nextRand(lcg);
			tests[k].ackDelay = {1'b0, lcg[31:29]};
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		featReq = 1'b0;
		featData = '0;
		tableExpValid = 1'b0;
		tableExp = '0;
		ackDone = 1'b0;
		buildTable();
		repeat (8)
			nextCycle();
		reset = 1'b0;
		for (int t = 0; t < TestCount; t++)
		begin
			tableExpValid = tests[t].hasExp;
			tableExp = tests[t].exp;
			for (int i = 0; i < nnPkg::FeatureCount; i++)
				sendFeature(tests[t].feats[i]);
		end
		while (!ackDone)
			nextCycle();
		nextCycle();
		$display("Summary: %0d passed, %0d failed, %0d of %0d results received",
			passCount, errorCount, resultCount, TestCount);
		if (errorCount == 0 && resultCount == TestCount)
		begin
			$display("*** TEST PASSED ***");
		end
		else
		begin
			if (resultCount != TestCount)
				$display("Number of results does not match the number of vectors sent");
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// Host side of the result port
	initial
	begin
		resultAck = 1'b0;
		nextCycle();
		while (reset)
			nextCycle();
		for (int r = 0; r < TestCount; r++)
		begin
			while (!resultReq)
				nextCycle();
			repeat (tests[r].ackDelay)
				nextCycle();
			resultAck = 1'b1;
			while (resultReq)
				nextCycle();
			resultAck = 1'b0;
			nextCycle();
		end
		ackDone = 1'b1;
	end

	initial
	begin
		cycles = 0;
		while (cycles < CycleLimit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run stopped after %0d cycles with %0d of %0d results received",
			cycles, resultCount, TestCount);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* project.f */
rtl/nnPkg.sv
rtl/featureReceiver.sv
rtl/neuronNode.sv
rtl/denseLayer.sv
rtl/classSelector.sv
rtl/resultSender.sv
rtl/inferenceTop.sv
dv/inferenceChecker.sv
dv/inferenceTb.sv
